/* build.f */
+incdir+include
hdl/cpuPkg.sv
hdl/aluArith.sv
hdl/aluLogic.sv
hdl/regFile.sv
hdl/instrDecoder.sv
hdl/pipeControl.sv
hdl/executeStage.sv
hdl/cpuTop.sv
verif/cpuTb_sva.sv
verif/cpuTb.sv

/* hdl/aluArith.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module aluArith (
    input  cpuPkg::opcodeE         op,
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    output logic [`DATA_WIDTH-1:0] result
);
    import cpuPkg::*;

    // Results wrap at the data width, shifts use the low nibble of b
    always_comb begin
        case (op)
            ADD, ADDI: begin
                result = a + b;
            end
            SUB: begin
                result = a - b;
            end
            SHL: begin
                result = a << b[3:0];
            end
            SHR: begin
                result = a >> b[3:0];
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* hdl/aluLogic.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module aluLogic (
    input  cpuPkg::opcodeE         op,
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    output logic [`DATA_WIDTH-1:0] result
);
    import cpuPkg::*;

    always_comb begin
        case (op)
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            LI:      result = b;
            // New upper byte from the immediate, low byte kept from rd
            LUI:     result = {b[7:0], a[7:0]};
            default: result = '0;
        endcase
    end

endmodule

/* hdl/cpuPkg.sv */
`include "cpu_settings.svh"

package cpuPkg;

    // Codes 13 to 15 are unused and retire as NOP
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        AND  = 4'd3,
        OR   = 4'd4,
        XOR  = 4'd5,
        SHL  = 4'd6,
        SHR  = 4'd7,
        LI   = 4'd8,
        LUI  = 4'd9,
        ADDI = 4'd10,
        JMP  = 4'd11,
        JAL  = 4'd12
    } opcodeE;

    typedef struct packed {
        opcodeE                     opcode;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
    } regFmtS;

    typedef struct packed {
        opcodeE                     opcode;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`IMM_WIDTH-1:0]      imm;
    } immFmtS;

    // One instruction word, two views sharing opcode and rd
    typedef union packed {
        regFmtS regFmt;
        immFmtS immFmt;
    } instrU;

    typedef struct packed {
        logic                 valid;
        instrU                instr;
        logic [`PC_WIDTH-1:0] pc;
    } fetchS;

    typedef enum logic [1:0] {
        ARITH,
        LOGIC,
        LINK
    } aluSelE;

    typedef struct packed {
        logic                       valid;
        opcodeE                     op;
        aluSelE                     sel;
        logic                       writeEn;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`DATA_WIDTH-1:0]     a;
        logic [`DATA_WIDTH-1:0]     b;
        logic [`DATA_WIDTH-1:0]     link;
    } issueS;

    // Register write port, also the bypass source for decode
    typedef struct packed {
        logic                       valid;
        logic [`REG_ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0]     data;
    } wbS;

endpackage

/* hdl/cpuTop.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpuTop (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 sysEn,
    input  cpuPkg::instrU        instr,
    output logic [`PC_WIDTH-1:0] instrAddr,
    output cpuPkg::wbS           wb
);
    import cpuPkg::*;

    fetchS                      fetch;
    logic                       jump;
    logic [`PC_WIDTH-1:0]       jumpTarget;
    logic [`REG_ADDR_WIDTH-1:0] readAddrA;
    logic [`REG_ADDR_WIDTH-1:0] readAddrB;
    logic [`DATA_WIDTH-1:0]     readDataA;
    logic [`DATA_WIDTH-1:0]     readDataB;
    issueS                      issue;

    pipeControl pipeCtl (
        .clk       (clk),
        .arstN     (arstN),
        .sysEn     (sysEn),
        .jump      (jump),
        .jumpTarget(jumpTarget),
        .instr     (instr),
        .instrAddr (instrAddr),
        .fetch     (fetch)
    );

    instrDecoder decoder (
        .fetch     (fetch),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .jump      (jump),
        .jumpTarget(jumpTarget),
        .issue     (issue)
    );

    regFile regs (
        .clk      (clk),
        .arstN    (arstN),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .wb       (wb),
        .readDataA(readDataA),
        .readDataB(readDataB)
    );

    executeStage exec (
        .clk  (clk),
        .arstN(arstN),
        .issue(issue),
        .wb   (wb)
    );

endmodule

/* hdl/executeStage.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module executeStage (
    input  logic          clk,
    input  logic          arstN,
    input  cpuPkg::issueS issue,
    output cpuPkg::wbS    wb
);
    import cpuPkg::*;

    issueS                  issueQ;
    logic [`DATA_WIDTH-1:0] arithResult;
    logic [`DATA_WIDTH-1:0] logicResult;

    // Issue register, decode to execute boundary
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            issueQ <= '0;
        end else begin
            issueQ <= issue;
        end
    end

    aluArith arithAlu (
        .op    (issueQ.op),
        .a     (issueQ.a),
        .b     (issueQ.b),
        .result(arithResult)
    );

    aluLogic logicAlu (
        .op    (issueQ.op),
        .a     (issueQ.a),
        .b     (issueQ.b),
        .result(logicResult)
    );

    // Writeback mux
    always_comb begin
        wb.valid = issueQ.valid && issueQ.writeEn;
        wb.addr  = issueQ.rd;
        case (issueQ.sel)
            ARITH:   wb.data = arithResult;
            LOGIC:   wb.data = logicResult;
            default: wb.data = issueQ.link;
        endcase
    end

endmodule

/* hdl/instrDecoder.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module instrDecoder (
    input  cpuPkg::fetchS              fetch,
    input  logic [`DATA_WIDTH-1:0]     readDataA,
    input  logic [`DATA_WIDTH-1:0]     readDataB,
    output logic [`REG_ADDR_WIDTH-1:0] readAddrA,
    output logic [`REG_ADDR_WIDTH-1:0] readAddrB,
    output logic                       jump,
    output logic [`PC_WIDTH-1:0]       jumpTarget,
    output cpuPkg::issueS              issue
);
    import cpuPkg::*;

    regFmtS                 rFmt;
    immFmtS                 iFmt;
    logic                   immOp;
    logic [`DATA_WIDTH-1:0] immZext;
    logic [`DATA_WIDTH-1:0] immSext;
    logic [`PC_WIDTH-1:0]   nextPc;

    assign rFmt    = fetch.instr.regFmt;
    assign iFmt    = fetch.instr.immFmt;
    assign immOp   = rFmt.opcode inside {LI, LUI, ADDI, JMP, JAL};
    assign immZext = {{(`DATA_WIDTH - `IMM_WIDTH){1'b0}}, iFmt.imm};
    assign immSext = {{(`DATA_WIDTH - `IMM_WIDTH){iFmt.imm[`IMM_WIDTH-1]}}, iFmt.imm};
    assign nextPc  = fetch.pc + 1'b1;

    // Immediate ops read their own destination as operand A
    assign readAddrA = immOp ? iFmt.rd : rFmt.rs;
    assign readAddrB = rFmt.rt;

    // Jumps resolve here, target is the absolute imm field
    assign jump       = fetch.valid && (rFmt.opcode == JMP || rFmt.opcode == JAL);
    assign jumpTarget = iFmt.imm;

    // Both formats place rd in the same bits
    always_comb begin
        issue         = '0;
        issue.valid   = fetch.valid;
        issue.op      = rFmt.opcode;
        issue.sel     = ARITH;
        issue.rd      = rFmt.rd;
        issue.a       = readDataA;
        issue.b       = readDataB;
        issue.link    = {{(`DATA_WIDTH - `PC_WIDTH){1'b0}}, nextPc};
        case (rFmt.opcode)
            ADD, SUB, SHL, SHR: begin
                issue.writeEn = 1'b1;
            end
            AND, OR, XOR: begin
                issue.sel     = LOGIC;
                issue.writeEn = 1'b1;
            end
            LI: begin
                issue.sel     = LOGIC;
                issue.a       = '0;
                issue.b       = immZext;
                issue.writeEn = 1'b1;
            end
            LUI: begin
                issue.sel     = LOGIC;
                issue.b       = immZext;
                issue.writeEn = 1'b1;
            end
            ADDI: begin
                issue.b       = immSext;
                issue.writeEn = 1'b1;
            end
            JAL: begin
                issue.sel     = LINK;
                issue.writeEn = 1'b1;
            end
            // NOP, JMP and the spare codes write nothing
            default: begin
                issue.writeEn = 1'b0;
            end
        endcase
    end

endmodule

/* hdl/pipeControl.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module pipeControl (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 sysEn,
    input  logic                 jump,
    input  logic [`PC_WIDTH-1:0] jumpTarget,
    input  cpuPkg::instrU        instr,
    output logic [`PC_WIDTH-1:0] instrAddr,
    output cpuPkg::fetchS        fetch
);

    logic [`PC_WIDTH-1:0] pc;

    // Memory answers in the same cycle, so the PC goes straight out
    assign instrAddr = pc;

    // A decoded jump redirects even while fetch is stopped
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (jump) begin
            pc <= jumpTarget;
        end else if (sysEn) begin
            pc <= pc + 1'b1;
        end
    end

    // Fetch register
    // Word fetched alongside a jump is wrong-path, held invalid
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetch <= '0;
        end else begin
            fetch.valid <= sysEn && !jump;
            fetch.instr <= instr;
            fetch.pc    <= pc;
        end
    end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module regFile (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddrA,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddrB,
    input  cpuPkg::wbS                 wb,
    output logic [`DATA_WIDTH-1:0]     readDataA,
    output logic [`DATA_WIDTH-1:0]     readDataB
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    // Architectural state, all registers read zero after reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // Write in flight bypasses the array
    assign readDataA = (wb.valid && wb.addr == readAddrA) ? wb.data : regs[readAddrA];
    assign readDataB = (wb.valid && wb.addr == readAddrB) ? wb.data : regs[readAddrB];

endmodule

/* include/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Register and data path width
`define DATA_WIDTH 16

// Architectural register count and its address width
`define REG_COUNT 16
`define REG_ADDR_WIDTH 4

// Instruction address width, PC wraps modulo 2**PC_WIDTH
`define PC_WIDTH 8

// Immediate field of the immediate format
`define IMM_WIDTH 8

`endif

/* verif/cpuTb.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpuTb;
    import cpuPkg::*;

    localparam int TEST_CYCLES = 1000;

    logic                       clk;
    logic                       arstN;
    logic                       sysEn;
    instrU                      instr;
    logic [`PC_WIDTH-1:0]       instrAddr;
    wbS                         wb;
    logic [`DATA_WIDTH-1:0]     prog [256];
    logic [`DATA_WIDTH-1:0]     refRegs [`REG_COUNT];
    logic [`PC_WIDTH-1:0]       refPc;
    logic [31:0]                lcgState;
    logic [`REG_ADDR_WIDTH-1:0] expAddr;
    logic [`DATA_WIDTH-1:0]     expData;
    logic [15:0]                rnd;
    int                         writeCount;
    int                         lowLeft;

    cpuTop UUT (
        .clk      (clk),
        .arstN    (arstN),
        .sysEn    (sysEn),
        .instr    (instr),
        .instrAddr(instrAddr),
        .wb       (wb)
    );

    bind cpuTop pipeChecks checks (
        .clk      (clk),
        .arstN    (arstN),
        .sysEn    (sysEn),
        .jump     (jump),
        .instrAddr(instrAddr),
        .wb       (wb)
    );

    // Instruction memory answers in the same cycle
    assign instr = prog[instrAddr];

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [15:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[30:15];
    endfunction

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // A third immediates, one in twelve jumps, the rest register ops
    task automatic fillProgram();
        logic [15:0] r;
        logic [15:0] f;
        logic [3:0]  op;
        int          sel;
        for (int a = 0; a < 256; a++) begin
            r   = nextRandom();
            f   = nextRandom();
            sel = r % 12;
            if (sel == 0) begin
                op = r[4] ? JAL : JMP;
                // Forward targets only, keeps jump chains from looping tightly
                prog[a] = {op, f[3:0], 8'(a + 2 + r[13:8])};
            end else if (sel <= 4) begin
                op      = (sel == 2) ? LUI : (sel == 3) ? ADDI : LI;
                prog[a] = {op, f[11:0]};
            end else begin
                prog[a] = {4'(sel - 4), f[11:0]};
            end
        end
        // Back-to-back pairs, second reads what the first writes
        for (int i = 0; i < 8; i++) begin
            r = nextRandom();
            f = nextRandom();
            prog[2*i]     = {LI, 4'(i), r[7:0]};
            prog[2*i + 1] = {4'(1 + r[15:8] % 7), f[3:0], 4'(i), 4'(i)};
        end
    endtask

    // ISA interpreter, runs ahead to the next register write
    task automatic nextWrite(output logic [3:0] addr, output logic [15:0] data);
        logic [15:0] w;
        logic [3:0]  op;
        logic [3:0]  rs;
        logic [3:0]  rt;
        logic [7:0]  imm;
        logic        found;
        int          guard;
        found = 1'b0;
        guard = 0;
        while (!found && guard < 256) begin
            w     = prog[refPc];
            op    = w[15:12];
            addr  = w[11:8];
            rs    = w[7:4];
            rt    = w[3:0];
            imm   = w[7:0];
            found = 1'b1;
            guard++;
            case (op)
                ADD:     data = refRegs[rs] + refRegs[rt];
                SUB:     data = refRegs[rs] - refRegs[rt];
                AND:     data = refRegs[rs] & refRegs[rt];
                OR:      data = refRegs[rs] | refRegs[rt];
                XOR:     data = refRegs[rs] ^ refRegs[rt];
                SHL:     data = refRegs[rs] << refRegs[rt][3:0];
                SHR:     data = refRegs[rs] >> refRegs[rt][3:0];
                LI:      data = {8'h00, imm};
                LUI:     data = {imm, refRegs[addr][7:0]};
                ADDI:    data = refRegs[addr] + {{8{imm[7]}}, imm};
                JAL:     data = {8'h00, refPc + 8'd1};
                default: found = 1'b0;
            endcase
            // Word after a jump never executes
            refPc = (op == JMP || op == JAL) ? imm : refPc + 8'd1;
            if (found) begin
                refRegs[addr] = data;
            end
        end
        if (!found) begin
            abortRun("Reference model ran 256 instructions without a register write");
        end
    endtask

    // Outputs settle after the rising edge, sampled mid-cycle
    always @(negedge clk) begin
        if (arstN && wb.valid) begin
            nextWrite(expAddr, expData);
            assert (wb.addr == expAddr && wb.data == expData)
                else abortRun($sformatf("error at %0t: write r%0d = %h, expected r%0d = %h",
                    $time, wb.addr, wb.data, expAddr, expData));
            writeCount++;
        end
    end

    // Stop at the first failure of a bound pipeline assertion
    always @(negedge clk) begin
        if (UUT.checks.failCount != 0) begin
            abortRun("A pipeline assertion on fetch or the write port failed");
        end
    end

    initial begin
        #((TEST_CYCLES + 100) * 40);
        abortRun("Timeout, the run did not finish within the expected time");
    end

    initial begin
        arstN      = 1'b0;
        sysEn      = 1'b0;
        lcgState   = 32'd435;
        refPc      = '0;
        writeCount = 0;
        lowLeft    = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            refRegs[i] = '0;
        end
        fillProgram();
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
        // Fetch stays off a little after reset
        repeat (2) @(posedge clk);
        sysEn <= 1'b1;
        for (int cyc = 0; cyc < TEST_CYCLES; cyc++) begin
            @(posedge clk);
            rnd = nextRandom();
            if (cyc < 24) begin
                sysEn <= 1'b1;
            end else if (lowLeft > 0) begin
                sysEn <= 1'b0;
                lowLeft--;
            end else if (rnd % 10 == 0) begin
                sysEn   <= 1'b0;
                lowLeft = rnd[5:4];
            end else begin
                sysEn <= 1'b1;
            end
        end
        if (writeCount > 200) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Only %0d register writes were checked, more than 200 needed", writeCount);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

endmodule

/* verif/cpuTb_sva.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module pipeChecks (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 sysEn,
    input  logic                 jump,
    input  logic [`PC_WIDTH-1:0] instrAddr,
    input  cpuPkg::wbS           wb
);

    logic startedQ;
    int   failCount = 0;

    // Set once fetch has been enabled after reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            startedQ <= 1'b0;
        end else if (sysEn) begin
            startedQ <= 1'b1;
        end
    end

    // Quiet start, PC parked at 0 and no writes
    idleAfterReset: assert property (@(posedge clk) disable iff (!arstN)
        !startedQ |-> (instrAddr == '0 && !wb.valid))
        else begin
            $error("instrAddr or write strobe active before first fetch enable");
            failCount++;
        end

    // PC frozen while fetch is stopped
    pcHolds: assert property (@(posedge clk) disable iff (!arstN)
        (!sysEn && !jump) |=> $stable(instrAddr))
        else begin
            $error("instrAddr moved with fetch disabled and no jump");
            failCount++;
        end

    // Fetch, decode, execute, so a write traces back two cycles
    writeNeedsFetch: assert property (@(posedge clk) disable iff (!arstN)
        wb.valid |-> $past(sysEn, 2))
        else begin
            $error("write strobe without fetch enable two cycles earlier");
            failCount++;
        end

endmodule
